// File: verilog/lr_cpu_pkg.sv
package lr_cpu_pkg;

  // ----------------------------------------------------------
  // Widths and reset address
  // ----------------------------------------------------------
  localparam int DATA_W    = 8;
  localparam int ADDR_W    = 16;
  localparam int REG_IDX_W = 3;

  typedef logic [DATA_W-1:0]    byte_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  localparam addr_t RESET_PC = 16'h0100;  // First opcode is fetched here.

  // ----------------------------------------------------------
  // Register indices, as encoded in the opcode fields
  // ----------------------------------------------------------
  localparam reg_idx_t REG_B      = 3'd0;
  localparam reg_idx_t REG_C      = 3'd1;
  localparam reg_idx_t REG_D      = 3'd2;
  localparam reg_idx_t REG_E      = 3'd3;
  localparam reg_idx_t REG_H      = 3'd4;
  localparam reg_idx_t REG_L      = 3'd5;
  localparam reg_idx_t IDX_HL_IND = 3'd6;  // Operand is the byte at (HL).
  localparam reg_idx_t REG_A      = 3'd7;

  typedef enum logic [3:0] {
    OP_NOP,
    LD_R_R,
    LD_R_N,
    LD_R_HL,
    LD_HL_R,
    LD_HL_N,
    LD_PTR_A,
    LD_A_PTR,
    LD_HLI_A,
    LD_A_HLI,
    LD_RR_NN
  } op_class_t;

  typedef enum logic [1:0] {
    PAIR_BC,
    PAIR_DE,
    PAIR_HL
  } pair_sel_t;

  typedef enum logic [1:0] {
    STEP_NONE,
    STEP_INC,
    STEP_DEC
  } ptr_step_t;

endpackage

// File: verilog/lr_fetch_unit.sv
module lr_fetch_unit (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_cap_opcode,
  input  logic              i_cap_lo,
  input  logic              i_cap_hi,
  input  lr_cpu_pkg::byte_t i_mem_rd_data,
  output lr_cpu_pkg::addr_t o_pc,
  output lr_cpu_pkg::byte_t o_opcode,
  output lr_cpu_pkg::addr_t o_imm16
);
  import lr_cpu_pkg::*;

  addr_t pc;
  byte_t opcode;
  byte_t imm_lo;
  byte_t imm_hi;
  logic  any_cap;

  assign any_cap = i_cap_opcode | i_cap_lo | i_cap_hi;

  // ----------------------------------------------------------
  // Program counter and instruction register
  // ----------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      pc     <= RESET_PC;
      opcode <= '0;  // Decodes as a no-op until the first fetch.
    end else begin
      if (any_cap) begin
        pc <= pc + ADDR_W'(1);  // Every captured byte consumes one address.
      end
      if (i_cap_opcode) begin
        opcode <= i_mem_rd_data;
      end
    end
  end

  // Immediate bytes.
  always_ff @(posedge i_clk) begin
    if (i_cap_lo) begin
      imm_lo <= i_mem_rd_data;
    end
    if (i_cap_hi) begin
      imm_hi <= i_mem_rd_data;
    end
  end

  assign o_pc     = pc;
  assign o_opcode = opcode;
  assign o_imm16  = {imm_hi, imm_lo};  // Eight-bit forms use the low byte only.

  // The sequencer reads one byte at a time, so it never asks for two captures at once.
  a_one_capture : assert property (@(posedge i_clk) disable iff (i_rst)
    $onehot0({i_cap_opcode, i_cap_lo, i_cap_hi}));

endmodule

// File: verilog/lr_decoder.sv
module lr_decoder (
  input  lr_cpu_pkg::byte_t     i_opcode,
  output lr_cpu_pkg::op_class_t o_op_class,
  output lr_cpu_pkg::reg_idx_t  o_dst_idx,
  output lr_cpu_pkg::reg_idx_t  o_src_idx,
  output lr_cpu_pkg::pair_sel_t o_pair_sel,
  output lr_cpu_pkg::ptr_step_t o_ptr_step
);
  import lr_cpu_pkg::*;

  logic dst_is_hl;
  logic src_is_hl;

  assign dst_is_hl = (i_opcode[5:3] == IDX_HL_IND);
  assign src_is_hl = (i_opcode[2:0] == IDX_HL_IND);

  always_comb begin
    o_op_class = OP_NOP;
    o_dst_idx  = i_opcode[5:3];
    o_src_idx  = i_opcode[2:0];
    o_pair_sel = PAIR_HL;  // Indirect forms without a pair field use HL.
    o_ptr_step = STEP_NONE;

    case (i_opcode[7:6])
      // --------------------------------------------------------
      // Block 01 holds the register and (HL) copies
      // --------------------------------------------------------
      2'b01: begin
        if (!dst_is_hl && !src_is_hl) begin
          o_op_class = LD_R_R;
        end else if (!dst_is_hl) begin
          o_op_class = LD_R_HL;
        end else if (!src_is_hl) begin
          o_op_class = LD_HL_R;
        end
        // Both fields at 6 is halt, which runs as a no-op.
      end

      // --------------------------------------------------------
      // Block 00 holds the immediates and pointer forms
      // --------------------------------------------------------
      2'b00: begin
        if (i_opcode[2:0] == 3'b110) begin
          o_op_class = dst_is_hl ? LD_HL_N : LD_R_N;
        end else if (i_opcode[3:0] == 4'h1 && i_opcode[5:4] != 2'b11) begin
          o_op_class = LD_RR_NN;  // Pair 3 is the stack pointer and is not kept.
          o_pair_sel = pair_sel_t'(i_opcode[5:4]);
        end else if (i_opcode[2:0] == 3'b010) begin
          o_src_idx = REG_A;  // Every form in this column moves A.
          o_dst_idx = REG_A;
          case (i_opcode[5:4])
            2'b00, 2'b01: begin
              o_op_class = i_opcode[3] ? LD_A_PTR : LD_PTR_A;
              o_pair_sel = pair_sel_t'(i_opcode[5:4]);
            end
            default: begin
              o_op_class = i_opcode[3] ? LD_A_HLI : LD_HLI_A;
              o_ptr_step = i_opcode[4] ? STEP_DEC : STEP_INC;
            end
          endcase
        end
      end

      default: ;
    endcase
  end

endmodule

// File: verilog/lr_reg_file.sv
module lr_reg_file (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_wr_en,
  input  logic                  i_pair_wr_en,
  input  lr_cpu_pkg::reg_idx_t  i_src_idx,
  input  lr_cpu_pkg::reg_idx_t  i_wr_idx,
  input  lr_cpu_pkg::byte_t     i_wr_data,
  input  lr_cpu_pkg::pair_sel_t i_pair_sel,
  input  lr_cpu_pkg::addr_t     i_pair_wr_data,
  output lr_cpu_pkg::byte_t     o_src_data,
  output lr_cpu_pkg::addr_t     o_bc,
  output lr_cpu_pkg::addr_t     o_de,
  output lr_cpu_pkg::addr_t     o_hl
);
  import lr_cpu_pkg::*;

  byte_t regs [2**REG_IDX_W];  // Slot 6 is never written and reads as zero.

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      for (int i = 0; i < 2**REG_IDX_W; i++) begin
        regs[i] <= '0;
      end
    end else if (i_pair_wr_en) begin
      case (i_pair_sel)
        PAIR_BC: {regs[REG_B], regs[REG_C]} <= i_pair_wr_data;
        PAIR_DE: {regs[REG_D], regs[REG_E]} <= i_pair_wr_data;
        default: {regs[REG_H], regs[REG_L]} <= i_pair_wr_data;
      endcase
    end else if (i_wr_en) begin
      regs[i_wr_idx] <= i_wr_data;
    end
  end

  assign o_src_data = regs[i_src_idx];
  assign o_bc       = {regs[REG_B], regs[REG_C]};
  assign o_de       = {regs[REG_D], regs[REG_E]};
  assign o_hl       = {regs[REG_H], regs[REG_L]};

  // The sequencer issues pair updates and byte loads in different states.
  a_one_writer : assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_wr_en && i_pair_wr_en));

  // Index 6 means memory, so the decoder must never route it to a byte write.
  a_no_hl_byte : assert property (@(posedge i_clk) disable iff (i_rst)
    i_wr_en |-> (i_wr_idx != IDX_HL_IND));

endmodule

// File: verilog/lr_sequencer.sv
module lr_sequencer (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  lr_cpu_pkg::op_class_t i_op_class,
  input  lr_cpu_pkg::reg_idx_t  i_dst_idx,
  input  lr_cpu_pkg::pair_sel_t i_pair_sel,
  input  lr_cpu_pkg::ptr_step_t i_ptr_step,
  input  lr_cpu_pkg::addr_t     i_pc,
  input  lr_cpu_pkg::addr_t     i_imm16,
  input  lr_cpu_pkg::addr_t     i_bc,
  input  lr_cpu_pkg::addr_t     i_de,
  input  lr_cpu_pkg::addr_t     i_hl,
  input  lr_cpu_pkg::byte_t     i_src_data,
  input  lr_cpu_pkg::byte_t     i_mem_rd_data,
  output logic                  o_cap_opcode,
  output logic                  o_cap_lo,
  output logic                  o_cap_hi,
  output logic                  o_wr_en,
  output logic                  o_pair_wr_en,
  output logic                  o_mem_wr_en,
  output lr_cpu_pkg::reg_idx_t  o_wr_idx,
  output lr_cpu_pkg::byte_t     o_wr_data,
  output lr_cpu_pkg::byte_t     o_mem_wr_data,
  output lr_cpu_pkg::addr_t     o_pair_wr_data,
  output lr_cpu_pkg::addr_t     o_mem_rd_addr,
  output lr_cpu_pkg::addr_t     o_mem_wr_addr
);
  import lr_cpu_pkg::*;

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    IMM_LO,
    IMM_HI,
    ACCESS,
    WRITEBACK
  } state_t;

  state_t state;
  state_t next_state;
  logic   phase;      // Second clock of a two-clock state.
  logic   two_clk;
  logic   last_clk;
  logic   is_load;
  logic   is_store;
  logic   step_now;
  addr_t  ptr;
  addr_t  hl_step;
  byte_t  imm_byte;
  byte_t  load_byte;

  assign is_load  = i_op_class inside {LD_R_HL, LD_A_PTR, LD_A_HLI};
  assign is_store = i_op_class inside {LD_HL_R, LD_HL_N, LD_PTR_A, LD_HLI_A};
  assign imm_byte = i_imm16[DATA_W-1:0];
  assign hl_step  = (i_ptr_step == STEP_DEC) ? i_hl - ADDR_W'(1) : i_hl + ADDR_W'(1);

  always_comb begin
    case (i_pair_sel)
      PAIR_BC: ptr = i_bc;
      PAIR_DE: ptr = i_de;
      default: ptr = i_hl;
    endcase
  end

  // ----------------------------------------------------------
  // State sequencing
  // ----------------------------------------------------------
  assign two_clk  = (state == FETCH) || (state == IMM_LO) || (state == IMM_HI) ||
                    ((state == ACCESS) && is_load);
  assign last_clk = !two_clk || phase;

  always_comb begin
    next_state = state;
    if (last_clk) begin
      case (state)
        FETCH: next_state = DECODE;
        DECODE: begin
          if (i_op_class == OP_NOP) next_state = FETCH;
          else if (i_op_class inside {LD_R_N, LD_HL_N, LD_RR_NN}) next_state = IMM_LO;
          else if (is_load || is_store) next_state = ACCESS;
          else next_state = WRITEBACK;
        end
        IMM_LO: begin
          if (i_op_class == LD_RR_NN) next_state = IMM_HI;
          else if (is_store) next_state = ACCESS;
          else next_state = WRITEBACK;
        end
        IMM_HI: next_state = WRITEBACK;
        ACCESS: next_state = is_load ? WRITEBACK : FETCH;
        default: next_state = FETCH;
      endcase
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state         <= FETCH;
      phase         <= 1'b0;
      o_mem_rd_addr <= RESET_PC;
    end else begin
      state <= next_state;
      phase <= two_clk && !phase;
      if (!phase) begin
        if (state == FETCH || state == IMM_LO || state == IMM_HI) begin
          o_mem_rd_addr <= i_pc;
        end else if (state == ACCESS && is_load) begin
          o_mem_rd_addr <= ptr;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == ACCESS && phase) begin
      load_byte <= i_mem_rd_data;  // Data for the address loaded one clock earlier.
    end
  end

  // ----------------------------------------------------------
  // Strobes and write controls
  // ----------------------------------------------------------
  assign o_cap_opcode = (state == FETCH) && phase;
  assign o_cap_lo     = (state == IMM_LO) && phase;
  assign o_cap_hi     = (state == IMM_HI) && phase;

  // HL steps on the last access clock, ahead of the A writeback.
  assign step_now       = (state == ACCESS) && last_clk && (i_ptr_step != STEP_NONE);
  assign o_pair_wr_en   = step_now || ((state == WRITEBACK) && (i_op_class == LD_RR_NN));
  assign o_pair_wr_data = step_now ? hl_step : i_imm16;

  assign o_wr_en  = (state == WRITEBACK) && (is_load || i_op_class inside {LD_R_R, LD_R_N});
  assign o_wr_idx = i_dst_idx;

  always_comb begin
    case (i_op_class)
      LD_R_R:  o_wr_data = i_src_data;
      LD_R_N:  o_wr_data = imm_byte;
      default: o_wr_data = load_byte;
    endcase
  end

  assign o_mem_wr_en   = (state == ACCESS) && is_store;
  assign o_mem_wr_addr = ptr;
  assign o_mem_wr_data = (i_op_class == LD_HL_N) ? imm_byte : i_src_data;

  // A store access lasts one clock and is always followed by a fetch.
  a_wr_pulse : assert property (@(posedge i_clk) disable iff (i_rst)
    o_mem_wr_en |=> !o_mem_wr_en);

endmodule

// File: verilog/lr_cpu_top.sv
module lr_cpu_top (
  input  logic              i_clk,
  input  logic              i_rst,
  input  lr_cpu_pkg::byte_t i_mem_rd_data,
  output lr_cpu_pkg::addr_t o_mem_rd_addr,
  output logic              o_mem_wr_en,
  output lr_cpu_pkg::addr_t o_mem_wr_addr,
  output lr_cpu_pkg::byte_t o_mem_wr_data
);

  logic                  cap_opcode;
  logic                  cap_lo;
  logic                  cap_hi;
  logic                  wr_en;
  logic                  pair_wr_en;
  lr_cpu_pkg::addr_t     pc;
  lr_cpu_pkg::byte_t     opcode;
  lr_cpu_pkg::addr_t     imm16;
  lr_cpu_pkg::op_class_t op_class;
  lr_cpu_pkg::reg_idx_t  dst_idx;
  lr_cpu_pkg::reg_idx_t  src_idx;
  lr_cpu_pkg::reg_idx_t  wr_idx;
  lr_cpu_pkg::pair_sel_t pair_sel;
  lr_cpu_pkg::ptr_step_t ptr_step;
  lr_cpu_pkg::byte_t     wr_data;
  lr_cpu_pkg::byte_t     src_data;
  lr_cpu_pkg::addr_t     pair_wr_data;
  lr_cpu_pkg::addr_t     bc;
  lr_cpu_pkg::addr_t     de;
  lr_cpu_pkg::addr_t     hl;

  lr_fetch_unit u_fetch (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_cap_opcode  (cap_opcode),
    .i_cap_lo      (cap_lo),
    .i_cap_hi      (cap_hi),
    .i_mem_rd_data (i_mem_rd_data),
    .o_pc          (pc),
    .o_opcode      (opcode),
    .o_imm16       (imm16)
  );

  lr_decoder u_decoder (
    .i_opcode   (opcode),
    .o_op_class (op_class),
    .o_dst_idx  (dst_idx),
    .o_src_idx  (src_idx),
    .o_pair_sel (pair_sel),
    .o_ptr_step (ptr_step)
  );

  lr_reg_file u_regs (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_wr_en        (wr_en),
    .i_pair_wr_en   (pair_wr_en),
    .i_src_idx      (src_idx),
    .i_wr_idx       (wr_idx),
    .i_wr_data      (wr_data),
    .i_pair_sel     (pair_sel),
    .i_pair_wr_data (pair_wr_data),
    .o_src_data     (src_data),
    .o_bc           (bc),
    .o_de           (de),
    .o_hl           (hl)
  );

  lr_sequencer u_seq (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_op_class     (op_class),
    .i_dst_idx      (dst_idx),
    .i_pair_sel     (pair_sel),
    .i_ptr_step     (ptr_step),
    .i_pc           (pc),
    .i_imm16        (imm16),
    .i_bc           (bc),
    .i_de           (de),
    .i_hl           (hl),
    .i_src_data     (src_data),
    .i_mem_rd_data  (i_mem_rd_data),
    .o_cap_opcode   (cap_opcode),
    .o_cap_lo       (cap_lo),
    .o_cap_hi       (cap_hi),
    .o_wr_en        (wr_en),
    .o_pair_wr_en   (pair_wr_en),
    .o_mem_wr_en    (o_mem_wr_en),
    .o_wr_idx       (wr_idx),
    .o_wr_data      (wr_data),
    .o_mem_wr_data  (o_mem_wr_data),
    .o_pair_wr_data (pair_wr_data),
    .o_mem_rd_addr  (o_mem_rd_addr),
    .o_mem_wr_addr  (o_mem_wr_addr)
  );

endmodule

// File: testbench/lr_cpu_tb.sv
module lr_cpu_tb;

  localparam logic [15:0] PROG_BASE   = 16'h0100;
  localparam int          TIMEOUT_CYC = 2000;
  localparam int          IDLE_CYC    = 200;
  localparam int          RAND_INSNS  = 40;

  localparam logic [2:0] IDX_B = 3'd0;
  localparam logic [2:0] IDX_C = 3'd1;
  localparam logic [2:0] IDX_D = 3'd2;
  localparam logic [2:0] IDX_E = 3'd3;
  localparam logic [2:0] IDX_H = 3'd4;
  localparam logic [2:0] IDX_L = 3'd5;
  localparam logic [2:0] IDX_M = 3'd6;  // Memory at HL.
  localparam logic [2:0] IDX_A = 3'd7;

  localparam logic [7:0] OPC_LD_BC_NN = 8'h01;
  localparam logic [7:0] OPC_LD_DE_NN = 8'h11;
  localparam logic [7:0] OPC_LD_HL_NN = 8'h21;
  localparam logic [7:0] OPC_LD_BC_A  = 8'h02;
  localparam logic [7:0] OPC_LD_DE_A  = 8'h12;
  localparam logic [7:0] OPC_LD_A_BC  = 8'h0A;
  localparam logic [7:0] OPC_LD_A_DE  = 8'h1A;
  localparam logic [7:0] OPC_LD_HLI_A = 8'h22;
  localparam logic [7:0] OPC_LD_HLD_A = 8'h32;
  localparam logic [7:0] OPC_LD_A_HLI = 8'h2A;
  localparam logic [7:0] OPC_LD_A_HLD = 8'h3A;
  localparam logic [7:0] OPC_LD_HL_N  = 8'h36;
  localparam logic [7:0] OPC_HALT     = 8'h76;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [7:0]  rd_data;
  logic [15:0] rd_addr;
  logic        wr_en;
  logic [15:0] wr_addr;
  logic [7:0]  wr_data;

  logic [7:0]  mem     [0:65535];
  logic [7:0]  ref_mem [0:65535];
  logic [23:0] exp_q   [$];  // Expected writes as {address, data}.
  logic [23:0] exp_w;
  int          prog_len = 0;
  int          seen_wr  = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          n_tests  = 0;

  lr_cpu_top UUT (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_mem_rd_data (rd_data),
    .o_mem_rd_addr (rd_addr),
    .o_mem_wr_en   (wr_en),
    .o_mem_wr_addr (wr_addr),
    .o_mem_wr_data (wr_data)
  );

  always #5 clk = ~clk;

  assign rd_data = mem[rd_addr];  // Asynchronous read port.

  // ----------------------------------------------------------
  // Write monitor that checks each pulse and then updates memory
  // ----------------------------------------------------------
  always @(negedge clk) begin
    if (!rst && wr_en) begin
      seen_wr  = seen_wr + 1;
      n_checks = n_checks + 1;
      assert (exp_q.size() != 0) else begin
        $display("ERROR %0t: unexpected write of %h to %h", $time, wr_data, wr_addr);
        n_errors = n_errors + 1;
      end
      if (exp_q.size() != 0) begin
        exp_w = exp_q.pop_front();
        assert ({wr_addr, wr_data} == exp_w) else begin
          $display("ERROR %0t: write %0d went to %h with %h, expected %h with %h",
                   $time, seen_wr, wr_addr, wr_data, exp_w[23:8], exp_w[7:0]);
          n_errors = n_errors + 1;
        end
      end
      mem[wr_addr] = wr_data;
    end
  end

  // ----------------------------------------------------------
  // Reference interpreter
  // ----------------------------------------------------------
  function automatic void record_store(input logic [15:0] addr, input logic [7:0] data);
    ref_mem[addr] = data;
    exp_q.push_back({addr, data});
  endfunction

  function automatic void run_reference(input int n_bytes);
    logic [7:0]  r [0:7];
    logic [15:0] pc;
    logic [15:0] hl;
    logic [7:0]  op;
    logic [7:0]  val;
    pc = PROG_BASE;
    for (int i = 0; i < 8; i++) begin
      r[i] = 8'h00;
    end
    while (int'(pc) < int'(PROG_BASE) + n_bytes) begin
      op = ref_mem[pc];
      pc = pc + 16'd1;
      hl = {r[IDX_H], r[IDX_L]};
      if (op[7:6] == 2'b01 && op != OPC_HALT) begin
        val = (op[2:0] == IDX_M) ? ref_mem[hl] : r[op[2:0]];
        if (op[5:3] == IDX_M) record_store(hl, val);
        else r[op[5:3]] = val;
      end else if (op[7:6] == 2'b00 && op[2:0] == 3'b110) begin
        val = ref_mem[pc];
        pc  = pc + 16'd1;
        if (op[5:3] == IDX_M) record_store(hl, val);
        else r[op[5:3]] = val;
      end else begin
        case (op)
          OPC_LD_BC_NN, OPC_LD_DE_NN, OPC_LD_HL_NN: begin
            r[{op[5:4], 1'b0}] = ref_mem[pc + 16'd1];  // High byte comes second.
            r[{op[5:4], 1'b1}] = ref_mem[pc];
            pc = pc + 16'd2;
          end
          OPC_LD_BC_A: record_store({r[IDX_B], r[IDX_C]}, r[IDX_A]);
          OPC_LD_DE_A: record_store({r[IDX_D], r[IDX_E]}, r[IDX_A]);
          OPC_LD_A_BC: r[IDX_A] = ref_mem[{r[IDX_B], r[IDX_C]}];
          OPC_LD_A_DE: r[IDX_A] = ref_mem[{r[IDX_D], r[IDX_E]}];
          OPC_LD_HLI_A: begin
            record_store(hl, r[IDX_A]);
            {r[IDX_H], r[IDX_L]} = hl + 16'd1;
          end
          OPC_LD_HLD_A: begin
            record_store(hl, r[IDX_A]);
            {r[IDX_H], r[IDX_L]} = hl - 16'd1;
          end
          OPC_LD_A_HLI: begin
            r[IDX_A] = ref_mem[hl];
            {r[IDX_H], r[IDX_L]} = hl + 16'd1;
          end
          OPC_LD_A_HLD: begin
            r[IDX_A] = ref_mem[hl];
            {r[IDX_H], r[IDX_L]} = hl - 16'd1;
          end
          default: ;  // Anything else is a one-byte no-op.
        endcase
      end
    end
  endfunction

  // ----------------------------------------------------------
  // Program building and test sequencing
  // ----------------------------------------------------------
  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return a[15:8] ^ {a[4:0], a[7:5]} ^ 8'h3C;
  endfunction

  function automatic logic [7:0] copy_op(input logic [2:0] dst, input logic [2:0] src);
    return {2'b01, dst, src};
  endfunction

  function automatic logic [7:0] imm_op(input logic [2:0] dst);
    return {2'b00, dst, 3'b110};
  endfunction

  task automatic emit(input logic [7:0] b);
    mem[int'(PROG_BASE) + prog_len] = b;
    prog_len++;
  endtask

  task automatic emit_n(input logic [7:0] op, input logic [7:0] n);
    emit(op);
    emit(n);
  endtask

  task automatic emit_nn(input logic [7:0] op, input logic [15:0] nn);
    emit(op);
    emit(nn[7:0]);
    emit(nn[15:8]);
  endtask

  task automatic begin_test();
    @(posedge clk);
    rst <= 1'b1;
    for (int a = 0; a < 65536; a++) begin
      mem[a] = (a >= 32'h8000) ? fill_byte(16'(a)) : 8'h00;  // Low half is all no-ops.
    end
    prog_len = 0;
  endtask

  task automatic check_idle_outputs(input string when_txt);
    n_checks++;
    assert (!wr_en && rd_addr == PROG_BASE) else begin
      $display("ERROR %0t: %s, wr_en=%b rd_addr=%h", $time, when_txt, wr_en, rd_addr);
      n_errors++;
    end
  endtask

  task automatic run_program(input string name);
    int err_start;
    int n_exp;
    int cyc;
    err_start = n_errors;
    exp_q.delete();
    seen_wr = 0;
    for (int a = 0; a < 65536; a++) begin
      ref_mem[a] = mem[a];
    end
    run_reference(prog_len);
    n_exp = exp_q.size();
    repeat (4) begin
      @(negedge clk);
      check_idle_outputs("during reset");
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle_outputs("after reset");
    for (int k = 0; k < n_exp; k++) begin
      cyc = 0;
      while (seen_wr <= k && cyc < TIMEOUT_CYC) begin
        @(posedge clk);
        cyc++;
      end
      if (seen_wr <= k) begin
        $display("Test %s timed out: write %0d of %0d never arrived", name, k + 1, n_exp);
        n_errors++;
        break;
      end
    end
    repeat (IDLE_CYC) @(posedge clk);  // Any write seen here is flagged by the monitor.
    n_tests++;
    $display("test %-10s %0d writes expected, %0d seen, %0d errors",
             name, n_exp, seen_wr, n_errors - err_start);
  endtask

  function automatic logic [7:0] high_byte();
    return 8'h90 + 8'($urandom % 96);  // Keeps pointers well away from the code.
  endfunction

  function automatic logic [2:0] safe_dst(input int k);
    case (k)
      0: return IDX_C;
      1: return IDX_E;
      2: return IDX_L;
      default: return IDX_A;
    endcase
  endfunction

  function automatic logic [7:0] unsupported_op(input int k);
    case (k)
      0: return 8'h00;
      1: return 8'h31;
      2: return OPC_HALT;
      3: return 8'h80;
      4: return 8'hC3;
      5: return 8'hE0;
      6: return 8'hF2;
      default: return 8'hFA;
    endcase
  endfunction

  task automatic immediate_loads();
    begin_test();
    emit_nn(OPC_LD_HL_NN, 16'h9010);
    emit_nn(OPC_LD_BC_NN, 16'hA020);
    emit_nn(OPC_LD_DE_NN, 16'hB030);
    emit_n(imm_op(IDX_A), 8'h11);
    emit(copy_op(IDX_M, IDX_A));
    emit(OPC_LD_BC_A);
    emit(OPC_LD_DE_A);
    emit_n(imm_op(IDX_C), 8'h22);
    emit(copy_op(IDX_M, IDX_C));
    emit_n(OPC_LD_HL_N, 8'h5C);
    run_program("immediate");
  endtask

  task automatic register_copies();
    begin_test();
    emit_nn(OPC_LD_HL_NN, 16'h9100);
    emit_n(imm_op(IDX_A), 8'h5A);
    emit(copy_op(IDX_B, IDX_A));
    emit(copy_op(IDX_C, IDX_B));
    emit(copy_op(IDX_D, IDX_C));
    emit(copy_op(IDX_E, IDX_D));
    emit(copy_op(IDX_M, IDX_B));
    emit(copy_op(IDX_M, IDX_C));
    emit(copy_op(IDX_M, IDX_D));
    emit(copy_op(IDX_M, IDX_E));
    emit_n(imm_op(IDX_A), 8'h93);
    emit(copy_op(IDX_H, IDX_A));
    emit(copy_op(IDX_L, IDX_H));  // HL is now 9393.
    emit(copy_op(IDX_M, IDX_L));
    emit(copy_op(IDX_A, IDX_E));
    emit(copy_op(IDX_M, IDX_A));
    run_program("copies");
  endtask

  task automatic memory_loads();
    begin_test();
    emit_nn(OPC_LD_HL_NN, 16'h9205);
    emit(copy_op(IDX_C, IDX_M));
    emit_nn(OPC_LD_DE_NN, 16'hA000);
    emit(copy_op(IDX_A, IDX_C));
    emit(OPC_LD_DE_A);
    emit_nn(OPC_LD_BC_NN, 16'hA1F0);
    emit(OPC_LD_A_BC);
    emit_nn(OPC_LD_HL_NN, 16'hC000);
    emit(copy_op(IDX_M, IDX_A));
    emit_nn(OPC_LD_DE_NN, 16'hB3C7);
    emit(OPC_LD_A_DE);
    emit(OPC_LD_BC_A);
    emit_nn(OPC_LD_HL_NN, 16'hA1F0);
    emit(copy_op(IDX_E, IDX_M));  // Reads back the byte stored just before.
    emit_nn(OPC_LD_HL_NN, 16'hC001);
    emit(copy_op(IDX_M, IDX_E));
    run_program("loads");
  endtask

  task automatic pointer_stepping();
    begin_test();
    emit_nn(OPC_LD_HL_NN, 16'h9400);
    emit_n(imm_op(IDX_A), 8'h11);
    emit(OPC_LD_HLI_A);
    emit(OPC_LD_HLI_A);
    emit_n(imm_op(IDX_A), 8'h22);
    emit(OPC_LD_HLD_A);
    emit(OPC_LD_HLD_A);
    emit(copy_op(IDX_M, IDX_A));
    emit_nn(OPC_LD_HL_NN, 16'h9480);
    emit(OPC_LD_A_HLI);
    emit(OPC_LD_HLD_A);
    emit(OPC_LD_A_HLD);
    emit(copy_op(IDX_M, IDX_A));
    run_program("stepping");
  endtask

  task automatic random_program();
    logic [2:0] d;
    logic [2:0] s;
    begin_test();
    emit_nn(OPC_LD_HL_NN, {high_byte(), 8'($urandom)});
    emit_nn(OPC_LD_BC_NN, {high_byte(), 8'($urandom)});
    emit_nn(OPC_LD_DE_NN, {high_byte(), 8'($urandom)});
    for (int i = 0; i < RAND_INSNS; i++) begin
      d = safe_dst($urandom % 4);  // B, D and H only change through high immediates.
      s = 3'($urandom % 7);
      if (s == IDX_M) s = IDX_A;
      case ($urandom % 12)
        0: emit(copy_op(d, s));
        1: begin
          d = 3'($urandom % 8);
          emit_n(imm_op(d), (d inside {IDX_B, IDX_D, IDX_H}) ? high_byte() : 8'($urandom));
        end
        2: emit(copy_op(d, IDX_M));
        3: emit(copy_op(IDX_M, s));
        4: emit_n(OPC_LD_HL_N, 8'($urandom));
        5: emit(($urandom % 2) ? OPC_LD_BC_A : OPC_LD_DE_A);
        6: emit(($urandom % 2) ? OPC_LD_A_BC : OPC_LD_A_DE);
        7: emit(($urandom % 2) ? OPC_LD_HLI_A : OPC_LD_HLD_A);
        8: emit(($urandom % 2) ? OPC_LD_A_HLI : OPC_LD_A_HLD);
        9: emit_nn({2'b00, 2'($urandom % 3), 4'h1}, {high_byte(), 8'($urandom)});
        default: emit(unsupported_op($urandom % 8));
      endcase
    end
    run_program("random");
  endtask

  initial begin
    void'($urandom(32'h62c5));
    begin_test();
    run_program("reset");  // The empty program runs only no-ops.
    immediate_loads();
    register_copies();
    memory_loads();
    pointer_stepping();
    random_program();
    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: flist.f
verilog/lr_cpu_pkg.sv
verilog/lr_fetch_unit.sv
verilog/lr_decoder.sv
verilog/lr_reg_file.sv
verilog/lr_sequencer.sv
verilog/lr_cpu_top.sv
testbench/lr_cpu_tb.sv

// File: Bender.yml
package:
  name: lr_cpu

sources:
  - verilog/lr_cpu_pkg.sv
  - verilog/lr_fetch_unit.sv
  - verilog/lr_decoder.sv
  - verilog/lr_reg_file.sv
  - verilog/lr_sequencer.sv
  - verilog/lr_cpu_top.sv
  - target: test
    files:
      - testbench/lr_cpu_tb.sv
